//--- common/glitch_pkg.sv
package glitch_pkg;

  // width of one pulse width entry in the table
  localparam int PULSE_W = 16;

  // host register map
  localparam logic [5:0] ADDR_OFFSET     = 6'd0;
  localparam logic [5:0] ADDR_NUM        = 6'd1;
  // 32..63 map onto table entries 0..31
  localparam logic [5:0] ADDR_TABLE_BASE = 6'd32;

  // sequencer configuration, owned by host_regs
  typedef struct packed {
    logic [31:0] offset;
    logic [4:0]  num_glitches;
  } glitch_cfg_t;

  // table entry view of a host data word
  typedef struct packed {
    logic [31-PULSE_W:0] rsvd;
    logic [PULSE_W-1:0]  width;
  } tbl_entry_t;

  // one host data word, decoded by address
  typedef union packed {
    logic [31:0] offset;
    tbl_entry_t  entry;
  } host_word_u;

  typedef struct packed {
    logic [5:0] addr;
    host_word_u data;
  } host_req_t;

  typedef struct packed {
    logic [4:0]         addr;
    logic [PULSE_W-1:0] width;
  } tbl_wr_t;

  typedef struct packed {
    logic       valid;
    logic [4:0] addr;
  } tbl_rd_t;

endpackage

//--- verilog/trigger_resync.sv
module trigger_resync #(
  parameter int pNUM_GLITCH_WIDTH = 5,
  parameter int pSYNC_STAGES = 2
) (
  input  logic                         clk,
  input  logic                         exttrig,
  input  logic                         trig_in,
  input  glitch_pkg::glitch_cfg_t      cfg,
  input  logic                         glitch_go,
  output logic                         fire,
  output logic [pNUM_GLITCH_WIDTH-1:0] index,
  output logic [pNUM_GLITCH_WIDTH-1:0] glitch_done_count,
  output logic                         done,
  output logic                         busy
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,
    S_NEXT,
    S_DONE
  } state_t;

  state_t state;

  logic                         trig_q;
  logic                         trig_rise;
  logic                         arm;
  logic [31:0]                  delay_cnt;
  glitch_pkg::glitch_cfg_t      cfg_q;
  logic [pNUM_GLITCH_WIDTH-1:0] num_q;
  logic                         last_glitch;

  // glitch_go synchronizer and edge detect
  logic [pSYNC_STAGES-1:0]      go_pipe;
  logic                         go_prev;
  logic                         go_fall;

  assign trig_rise = trig_in & ~trig_q;
  // a zero glitch count never leaves idle
  assign arm = (state == S_IDLE) && trig_rise && (cfg.num_glitches != '0);
  assign num_q = pNUM_GLITCH_WIDTH'(cfg_q.num_glitches);
  assign last_glitch = (index == num_q - 1'b1);
  assign go_fall = go_prev & ~go_pipe[pSYNC_STAGES-1];
  assign busy = (state != S_IDLE);

  // settings are frozen for the whole run at arm time
  always_ff @(posedge clk) begin
    if (arm) begin
      cfg_q <= cfg;
    end
  end

  // count finished glitches so the run waits for the last pulse
  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      go_pipe <= '0;
      go_prev <= 1'b0;
      glitch_done_count <= '0;
    end else begin
      go_pipe[0] <= glitch_go;
      for (int i = 1; i < pSYNC_STAGES; i++) begin
        go_pipe[i] <= go_pipe[i-1];
      end
      go_prev <= go_pipe[pSYNC_STAGES-1];
      if (state == S_IDLE) begin
        glitch_done_count <= '0;
      end else if (go_fall) begin
        glitch_done_count <= glitch_done_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      state <= S_IDLE;
      trig_q <= 1'b0;
      delay_cnt <= '0;
      index <= '0;
      fire <= 1'b0;
      done <= 1'b0;
    end else begin
      trig_q <= trig_in;
      fire <= 1'b0;
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          index <= '0;
          delay_cnt <= '0;
          if (arm) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          // offset+1 cycles from 0 up to offset, then fire
          if (delay_cnt == cfg_q.offset) begin
            fire <= 1'b1;
            delay_cnt <= '0;
            state <= last_glitch ? S_DONE : S_NEXT;
          end else begin
            delay_cnt <= delay_cnt + 1'b1;
          end
        end
        S_NEXT: begin
          // index stays put through fire, steps here
          index <= index + 1'b1;
          state <= S_WAIT;
        end
        S_DONE: begin
          // trigger must be released too, a held trigger stretches the run
          if (!trig_in && (glitch_done_count == num_q)) begin
            done <= 1'b1;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

//--- verilog/host_regs.sv
module host_regs (
  input  logic                    clk,
  input  logic                    exttrig,
  input  logic                    req,
  input  glitch_pkg::host_req_t   host_req,
  output logic                    ack,
  output glitch_pkg::glitch_cfg_t cfg,
  output glitch_pkg::tbl_wr_t     tbl_wr,
  output logic                    wr_req,
  input  logic                    wr_gnt
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REG,
    S_TBL,
    S_ACK
  } state_t;

  state_t state;

  // captured host word, held until the handshake closes
  glitch_pkg::host_req_t hreq_q;

  assign ack = (state == S_ACK);
  assign wr_req = (state == S_TBL);

  // table index is the address above the table base
  always_comb begin
    tbl_wr.addr = hreq_q.addr[4:0];
    tbl_wr.width = hreq_q.data.entry.width;
  end

  always_ff @(posedge clk) begin
    if ((state == S_IDLE) && req) begin
      hreq_q <= host_req;
    end
  end

  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      state <= S_IDLE;
      cfg <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (req) begin
            state <= (host_req.addr >= glitch_pkg::ADDR_TABLE_BASE) ? S_TBL : S_REG;
          end
        end
        S_REG: begin
          // unknown register addresses are acked and dropped
          if (hreq_q.addr == glitch_pkg::ADDR_OFFSET) begin
            cfg.offset <= hreq_q.data.offset;
          end else if (hreq_q.addr == glitch_pkg::ADDR_NUM) begin
            // count lives in the low bits of the plain word
            cfg.num_glitches <= hreq_q.data.offset[4:0];
          end
          state <= S_ACK;
        end
        S_TBL: begin
          // memory takes the write on the granted edge
          if (wr_gnt) begin
            state <= S_ACK;
          end
        end
        S_ACK: begin
          if (!req) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

//--- glitch_table/glitch_table.sv
module glitch_table #(
  parameter int pMAX_GLITCHES = 32
) (
  input  logic                           clk,
  input  logic                           exttrig,
  input  glitch_pkg::tbl_rd_t            tbl_rd,
  output logic [glitch_pkg::PULSE_W-1:0] rd_width,
  input  glitch_pkg::tbl_wr_t            tbl_wr,
  input  logic                           wr_req,
  output logic                           wr_gnt
);

  // every entry starts as a one cycle pulse
  localparam logic [glitch_pkg::PULSE_W-1:0] reset_width =
    {{(glitch_pkg::PULSE_W-1){1'b0}}, 1'b1};

  logic [glitch_pkg::PULSE_W-1:0] mem [pMAX_GLITCHES];

  logic wr_en;

  // single port, the pulse generator read always wins
  assign wr_gnt = wr_req & ~tbl_rd.valid;
  // writes past the table depth are dropped
  assign wr_en = wr_gnt && (tbl_wr.addr < pMAX_GLITCHES);

  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      for (int i = 0; i < pMAX_GLITCHES; i++) begin
        mem[i] <= reset_width;
      end
    end else if (wr_en) begin
      mem[tbl_wr.addr] <= tbl_wr.width;
    end
  end

  // registered read, data valid the cycle after the request
  always_ff @(posedge clk) begin
    if (tbl_rd.valid) begin
      rd_width <= mem[tbl_rd.addr];
    end
  end

endmodule

//--- glitch_pulse/glitch_pulse_gen.sv
module glitch_pulse_gen #(
  parameter int pNUM_GLITCH_WIDTH = 5
) (
  input  logic                           clk,
  input  logic                           exttrig,
  input  logic                           fire,
  input  logic [pNUM_GLITCH_WIDTH-1:0]   index,
  output glitch_pkg::tbl_rd_t            tbl_rd,
  input  logic [glitch_pkg::PULSE_W-1:0] rd_width,
  output logic                           glitch_out,
  output logic                           glitch_go
);

  // read issued last cycle, rd_width is valid now
  logic                           rd_pend;
  logic [glitch_pkg::PULSE_W-1:0] cnt;

  // one-deep slot for a fire that lands during a pulse
  logic                           pend_valid;
  logic [pNUM_GLITCH_WIDTH-1:0]   pend_idx;

  logic can_issue;
  logic issue_pend;
  logic issue_fire;
  logic to_pend;

  // a read may go out in the last cycle of a pulse, leaving one low cycle
  assign can_issue = ~rd_pend && (cnt[glitch_pkg::PULSE_W-1:1] == '0);
  assign issue_pend = can_issue & pend_valid;
  assign issue_fire = can_issue & ~pend_valid & fire;
  assign to_pend = fire & ~issue_fire;

  always_comb begin
    tbl_rd.valid = issue_pend | issue_fire;
    tbl_rd.addr = issue_pend ? pend_idx : index;
  end

  assign glitch_out = (cnt != '0);
  // returned to the sequencer as the finished-glitch strobe
  assign glitch_go = glitch_out;

  always_ff @(posedge clk) begin
    if (to_pend) begin
      pend_idx <= index;
    end
  end

  always_ff @(posedge clk or posedge exttrig) begin
    if (exttrig) begin
      rd_pend <= 1'b0;
      cnt <= '0;
      pend_valid <= 1'b0;
    end else begin
      rd_pend <= tbl_rd.valid;
      // zero width stretched to one cycle
      if (rd_pend) begin
        cnt <= rd_width | {{(glitch_pkg::PULSE_W-1){1'b0}}, (rd_width == '0)};
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
      // slot refilled by a new fire even while it is being promoted
      if (to_pend) begin
        pend_valid <= 1'b1;
      end else if (issue_pend) begin
        pend_valid <= 1'b0;
      end
    end
  end

endmodule

//--- verilog/glitch_top.sv
module glitch_top #(
  parameter int pMAX_GLITCHES = 32,
  parameter int pNUM_GLITCH_WIDTH = 5,
  parameter int pSYNC_STAGES = 2
) (
  input  logic                         clk,
  input  logic                         exttrig,
  input  logic                         trig_in,
  input  logic                         req,
  input  glitch_pkg::host_req_t        host_req,
  output logic                         ack,
  output logic                         glitch_out,
  output logic                         done,
  output logic                         busy,
  output logic [pNUM_GLITCH_WIDTH-1:0] glitch_done_count
);

  glitch_pkg::glitch_cfg_t        cfg;
  glitch_pkg::tbl_wr_t            tbl_wr;
  glitch_pkg::tbl_rd_t            tbl_rd;
  logic                           wr_req;
  logic                           wr_gnt;
  logic [glitch_pkg::PULSE_W-1:0] rd_width;
  logic                           fire;
  logic [pNUM_GLITCH_WIDTH-1:0]   index;
  logic                           glitch_go;

  // host side register port
  host_regs u_host_regs (
    .clk      (clk),
    .exttrig  (exttrig),
    .req      (req),
    .host_req (host_req),
    .ack      (ack),
    .cfg      (cfg),
    .tbl_wr   (tbl_wr),
    .wr_req   (wr_req),
    .wr_gnt   (wr_gnt)
  );

  glitch_table #(
    .pMAX_GLITCHES (pMAX_GLITCHES)
  ) u_glitch_table (
    .clk      (clk),
    .exttrig  (exttrig),
    .tbl_rd   (tbl_rd),
    .rd_width (rd_width),
    .tbl_wr   (tbl_wr),
    .wr_req   (wr_req),
    .wr_gnt   (wr_gnt)
  );

  trigger_resync #(
    .pNUM_GLITCH_WIDTH (pNUM_GLITCH_WIDTH),
    .pSYNC_STAGES      (pSYNC_STAGES)
  ) u_trigger_resync (
    .clk               (clk),
    .exttrig           (exttrig),
    .trig_in           (trig_in),
    .cfg               (cfg),
    .glitch_go         (glitch_go),
    .fire              (fire),
    .index             (index),
    .glitch_done_count (glitch_done_count),
    .done              (done),
    .busy              (busy)
  );

  // pulse output stage
  glitch_pulse_gen #(
    .pNUM_GLITCH_WIDTH (pNUM_GLITCH_WIDTH)
  ) u_glitch_pulse_gen (
    .clk        (clk),
    .exttrig    (exttrig),
    .fire       (fire),
    .index      (index),
    .tbl_rd     (tbl_rd),
    .rd_width   (rd_width),
    .glitch_out (glitch_out),
    .glitch_go  (glitch_go)
  );

endmodule

//--- test/tb_glitch_top.sv
module tb_glitch_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PW = glitch_pkg::PULSE_W;
  localparam int NUM_W = 5;
  // about twice the summed length of all tests
  localparam int MAX_CYCLES = 4000;
  localparam int HS_LIMIT = 50;

  logic                  clk;
  logic                  exttrig;
  logic                  trig_in;
  logic                  req;
  glitch_pkg::host_req_t host_req;
  logic                  ack;
  logic                  glitch_out;
  logic                  done;
  logic                  busy;
  logic [NUM_W-1:0]      glitch_done_count;

  int          cycle = 0;
  int          mismatches = 0;
  int          failures = 0;
  logic [31:0] rng_state = 32'd81298;

  // pulse record filled by measure_pulses
  int               starts[$];
  int               widths[$];
  int               done_cycle;
  logic [NUM_W-1:0] done_cnt;
  logic             busy_seen;
  // widths the current run should produce, in index order
  logic [PW-1:0]    exp_widths[$];

  glitch_top #(
    .pMAX_GLITCHES     (32),
    .pNUM_GLITCH_WIDTH (NUM_W),
    .pSYNC_STAGES      (2)
  ) u_dut (
    .clk               (clk),
    .exttrig           (exttrig),
    .trig_in           (trig_in),
    .req               (req),
    .host_req          (host_req),
    .ack               (ack),
    .glitch_out        (glitch_out),
    .done              (done),
    .busy              (busy),
    .glitch_done_count (glitch_done_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // cycle count, also the run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle == MAX_CYCLES) begin
      $display("timeout: run still going after %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare_width(input logic [PW-1:0] got, input logic [PW-1:0] exp,
                               input string what);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic compare_count(input logic [NUM_W-1:0] got, input logic [NUM_W-1:0] exp,
                               input string what);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic compare_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("mismatch at %0d ns: %s got cycle %0d expected %0d", $time, what, got, exp);
      mismatches++;
    end
  endtask

  // four-phase write, req held until ack, then released
  task automatic host_write(input logic [5:0] addr, input glitch_pkg::host_word_u word);
    int wait_n;
    @(posedge clk);
    #1;
    host_req.addr = addr;
    host_req.data = word;
    req = 1'b1;
    wait_n = 0;
    // table writes may sit behind pulse reads
    while (!ack && wait_n < HS_LIMIT) begin
      @(negedge clk);
      wait_n++;
    end
    if (!ack) begin
      $display("host write to address %0d was never acknowledged", addr);
      failures++;
    end
    @(posedge clk);
    #1;
    req = 1'b0;
    wait_n = 0;
    while (ack && wait_n < HS_LIMIT) begin
      @(negedge clk);
      wait_n++;
    end
    if (ack) begin
      $display("ack stayed high after req dropped for address %0d", addr);
      failures++;
    end
  endtask

  task automatic write_reg(input logic [5:0] addr, input logic [31:0] val);
    glitch_pkg::host_word_u word;
    word.offset = val;
    host_write(addr, word);
  endtask

  task automatic write_width(input int idx, input logic [PW-1:0] w);
    glitch_pkg::host_word_u word;
    word.entry.rsvd = '0;
    word.entry.width = w;
    host_write(glitch_pkg::ADDR_TABLE_BASE | 6'(idx), word);
  endtask

  task automatic drive_trig(input logic v, output int at);
    @(posedge clk);
    #1;
    trig_in = v;
    at = cycle;
  endtask

  // short trigger pulse, released well before the run ends
  task automatic fire_trigger(output int at);
    int unused;
    drive_trig(1'b1, at);
    repeat (2) @(posedge clk);
    drive_trig(1'b0, unused);
  endtask

  // sampled on the falling edge, stops at done or after window cycles
  task automatic measure_pulses(input int window);
    int n;
    int width;
    logic prev;
    starts.delete();
    widths.delete();
    done_cycle = -1;
    done_cnt = '0;
    busy_seen = 1'b0;
    prev = 1'b0;
    width = 0;
    for (n = 0; n < window && done_cycle < 0; n++) begin
      @(negedge clk);
      if (busy) busy_seen = 1'b1;
      if (glitch_out) begin
        if (!prev) starts.push_back(cycle);
        width++;
      end else if (prev) begin
        widths.push_back(width);
        width = 0;
      end
      prev = glitch_out;
      if (done) begin
        done_cycle = cycle;
        done_cnt = glitch_done_count;
      end
    end
  endtask

  task automatic check_run(input int trig_c, input int off, input string tag);
    int i;
    int exp_start;
    int last_end;
    logic [PW-1:0] ew;
    compare_count(NUM_W'(starts.size()), NUM_W'(exp_widths.size()), {tag, " pulse count"});
    last_end = 0;
    for (i = 0; i < exp_widths.size(); i++) begin
      // zero width runs as one cycle
      ew = (exp_widths[i] == '0) ? PW'(1) : exp_widths[i];
      // arm, offset+1 count, read and load, then offset+2 per further fire
      exp_start = trig_c + off + 4 + i * (off + 2);
      // a pending fire waits one low cycle after the pulse before it
      if (i > 0 && last_end + 1 > exp_start) exp_start = last_end + 1;
      if (i < starts.size()) begin
        compare_cycles(starts[i], exp_start, $sformatf("%s start %0d", tag, i));
      end
      if (i < widths.size()) begin
        compare_width(PW'(widths[i]), ew, $sformatf("%s width %0d", tag, i));
      end
      last_end = exp_start + int'(ew);
    end
    if (done_cycle < 0) begin
      $display("%s: done never pulsed", tag);
      failures++;
    end else begin
      if (done_cycle < last_end) begin
        $display("%s: done came before the last pulse ended", tag);
        failures++;
      end
      compare_count(done_cnt, NUM_W'(exp_widths.size()), {tag, " done count"});
    end
  endtask

  task automatic single_glitch();
    int k;
    write_reg(glitch_pkg::ADDR_OFFSET, 32'd10);
    write_reg(glitch_pkg::ADDR_NUM, 32'd1);
    write_width(0, PW'(5));
    exp_widths.delete();
    exp_widths.push_back(PW'(5));
    fork
      fire_trigger(k);
      measure_pulses(200);
    join
    check_run(k, 10, "single glitch");
  endtask

  task automatic per_index_widths();
    int k;
    int i;
    logic [PW-1:0] w;
    write_reg(glitch_pkg::ADDR_OFFSET, 32'd12);
    write_reg(glitch_pkg::ADDR_NUM, 32'd4);
    exp_widths.delete();
    for (i = 0; i < 4; i++) begin
      rng_state = xorshift(rng_state);
      w = PW'(1 + rng_state % 6);
      write_width(i, w);
      exp_widths.push_back(w);
    end
    fork
      fire_trigger(k);
      measure_pulses(300);
    join
    check_run(k, 12, "per-index widths");
  endtask

  // second fire lands mid pulse and waits in the pending slot
  task automatic pending_slot();
    int k;
    write_reg(glitch_pkg::ADDR_OFFSET, 32'd3);
    write_reg(glitch_pkg::ADDR_NUM, 32'd2);
    write_width(0, PW'(20));
    write_width(1, PW'(20));
    exp_widths.delete();
    exp_widths.push_back(PW'(20));
    exp_widths.push_back(PW'(20));
    fork
      fire_trigger(k);
      measure_pulses(200);
    join
    check_run(k, 3, "pending slot");
  endtask

  task automatic zero_count_idle();
    int k;
    write_reg(glitch_pkg::ADDR_NUM, 32'd0);
    fork
      fire_trigger(k);
      measure_pulses(60);
    join
    compare_count(NUM_W'(starts.size()), '0, "zero count pulses");
    if (done_cycle >= 0) begin
      $display("done pulsed although the glitch count was zero");
      failures++;
    end
    if (busy_seen) begin
      $display("busy went high although the glitch count was zero");
      failures++;
    end
  endtask

  task automatic held_trigger();
    int k;
    int t;
    int fall;
    write_reg(glitch_pkg::ADDR_OFFSET, 32'd5);
    write_reg(glitch_pkg::ADDR_NUM, 32'd2);
    write_width(0, PW'(3));
    write_width(1, PW'(3));
    exp_widths.delete();
    exp_widths.push_back(PW'(3));
    exp_widths.push_back(PW'(3));
    fork
      measure_pulses(150);
      begin
        drive_trig(1'b1, k);
        repeat (8) @(posedge clk);
        drive_trig(1'b0, t);
        @(posedge clk);
        // second rise while the run is still counting
        drive_trig(1'b1, t);
        if (!busy) begin
          $display("sequencer was idle at the second trigger edge");
          failures++;
        end
        // held well past the last pulse
        repeat (24) @(posedge clk);
        drive_trig(1'b0, fall);
      end
    join
    check_run(k, 5, "held trigger");
    // release is seen on the next edge
    compare_cycles(done_cycle, fall + 1, "held trigger done");
    measure_pulses(30);
    compare_count(NUM_W'(starts.size()), '0, "held trigger extra pulses");
    if (done_cycle >= 0) begin
      $display("done pulsed a second time after the held trigger run");
      failures++;
    end
  endtask

  task automatic cfg_write_while_busy();
    int k;
    int new_off;
    rng_state = xorshift(rng_state);
    new_off = 4 + int'(rng_state % 8);
    write_reg(glitch_pkg::ADDR_OFFSET, 32'd6);
    write_reg(glitch_pkg::ADDR_NUM, 32'd2);
    write_width(0, PW'(2));
    write_width(1, PW'(2));
    write_width(2, PW'(2));
    exp_widths.delete();
    exp_widths.push_back(PW'(2));
    exp_widths.push_back(PW'(2));
    fork
      begin
        fire_trigger(k);
        if (!busy) begin
          $display("sequencer was not busy when the new settings were written");
          failures++;
        end
        write_reg(glitch_pkg::ADDR_OFFSET, 32'(new_off));
        write_reg(glitch_pkg::ADDR_NUM, 32'd3);
      end
      measure_pulses(200);
    join
    check_run(k, 6, "busy write current run");
    // the next run picks up the new offset and count
    exp_widths.push_back(PW'(2));
    fork
      fire_trigger(k);
      measure_pulses(200);
    join
    check_run(k, new_off, "busy write next run");
  endtask

  initial begin
    exttrig = 1'b1;
    trig_in = 1'b0;
    req = 1'b0;
    host_req = '0;
    repeat (3) @(posedge clk);
    #1;
    exttrig = 1'b0;
    @(negedge clk);
    if (glitch_out || done || busy || ack) begin
      $display("outputs were not all low after reset");
      failures++;
    end
    single_glitch();
    per_index_widths();
    pending_slot();
    zero_count_idle();
    held_trigger();
    cfg_write_while_busy();
    repeat (5) @(posedge clk);
    if (mismatches + failures == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $display("mismatches %0d, other failures %0d", mismatches, failures);
    $finish;
  end

endmodule

//--- sources.f
common/glitch_pkg.sv
verilog/trigger_resync.sv
verilog/host_regs.sv
glitch_table/glitch_table.sv
glitch_pulse/glitch_pulse_gen.sv
verilog/glitch_top.sv
test/tb_glitch_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the glitch sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_glitch_top -Mdir obj_dir -o tb_glitch_top -f sources.f > build.log 2>&1 \
  && ./obj_dir/tb_glitch_top > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
